/* hw/icache_pkg.sv */
// Shared widths, sizes and entry types of the two-way instruction cache.
// Every cache module refers to these by scoped name.
package icache_pkg;

    // fetch address layout is tag [31:9], index [8:3], word select [2].
    localparam int ADDR_W = 32;
    localparam int TAG_W = 23;
    localparam int INDEX_W = 6;

    localparam int SETS = 64;  // one entry per index value.

    // a line holds two instructions and matches the memory data width.
    localparam int LINE_W = 64;
    localparam int INST_W = 32;

    // victim selection state per way and set.
    localparam int AGE_W = 3;
    localparam int AGE_MAX = 7;

    // one tag array entry.
    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
    } tag_entry_t;

    typedef logic [LINE_W-1:0] line_t;

endpackage

/* hw/icache_sram.sv */
`timescale 1ns/1ns
// Synchronous single-port array with one entry per cache set.
// The entry type is a parameter, so the same array holds tags or data lines.
module icache_sram #(
    parameter type entry_t = icache_pkg::line_t
) (
    input  logic                         clk,
    input  logic [icache_pkg::INDEX_W-1:0] addr_i,
    input  logic                         we_i,
    input  entry_t                       wdata_i,
    output entry_t                       rdata_o
);

    entry_t mem [icache_pkg::SETS];

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[addr_i] <= wdata_i;
        end
    end

    // read is registered every cycle and a write shows up on the next one.
    always_ff @(posedge clk) begin
        if (we_i) begin
            rdata_o <= wdata_i;
        end else begin
            rdata_o <= mem[addr_i];
        end
    end

endmodule

/* hw/icache_age.sv */
`timescale 1ns/1ns
// Per-set age counters for both cache ways.
// Every delivered fetch ages all entries; the way that was used is made young.
// The victim output names the older way of the indexed set.
module icache_age (
    input  logic                           clk,
    input  logic                           reset_i,
    input  logic [icache_pkg::INDEX_W-1:0] index_i,
    input  logic                           touch_i,
    input  logic                           touch_way_i,
    input  logic                           deliver_i,
    output logic                           victim_way_o
);

    logic [icache_pkg::AGE_W-1:0] age0 [icache_pkg::SETS];
    logic [icache_pkg::AGE_W-1:0] age1 [icache_pkg::SETS];

    function automatic logic [icache_pkg::AGE_W-1:0] age_next(
        input logic [icache_pkg::AGE_W-1:0] age
    );
        if (age == icache_pkg::AGE_W'(icache_pkg::AGE_MAX)) begin
            return age;  // counters saturate.
        end
        return age + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < icache_pkg::SETS; i++) begin
                age0[i] <= '0;
                age1[i] <= '0;
            end
        end else begin
            for (int i = 0; i < icache_pkg::SETS; i++) begin
                if (touch_i && !touch_way_i && index_i == i[icache_pkg::INDEX_W-1:0]) begin
                    age0[i] <= '0;  // a touch wins over the aging step.
                end else if (deliver_i) begin
                    age0[i] <= age_next(age0[i]);
                end
                if (touch_i && touch_way_i && index_i == i[icache_pkg::INDEX_W-1:0]) begin
                    age1[i] <= '0;
                end else if (deliver_i) begin
                    age1[i] <= age_next(age1[i]);
                end
            end
        end
    end

    // ties go to way 0.
    assign victim_way_o = (age0[index_i] >= age1[index_i]) ? 1'b0 : 1'b1;

endmodule

/* hw/icache_ctrl.sv */
`timescale 1ns/1ns
// Cache controller: lookup, hit response, line refill and fence walk.
// Arrays are read one cycle after their address is driven.
module icache_ctrl (
    input  logic                           clk,
    input  logic                           reset_i,
    input  logic                           fetch_req_i,
    input  logic [icache_pkg::ADDR_W-1:0]  fetch_addr_i,
    input  logic                           fence_i,
    output logic                           fetch_ready_o,
    output logic                           fetch_valid_o,
    output logic [icache_pkg::INST_W-1:0]  fetch_data_o,
    output logic                           mem_req_o,
    output logic [icache_pkg::ADDR_W-1:0]  mem_addr_o,
    input  logic                           mem_valid_i,
    input  icache_pkg::line_t              mem_data_i,
    output logic [icache_pkg::INDEX_W-1:0] arr_addr_o,
    output logic [1:0]                     tag_we_o,
    output icache_pkg::tag_entry_t         tag_wdata_o,
    input  icache_pkg::tag_entry_t         tag0_rdata_i,
    input  icache_pkg::tag_entry_t         tag1_rdata_i,
    output logic [1:0]                     data_we_o,
    input  icache_pkg::line_t              data0_rdata_i,
    input  icache_pkg::line_t              data1_rdata_i,
    output logic                           age_touch_o,
    output logic                           age_way_o,
    output logic                           age_deliver_o,
    input  logic                           victim_way_i
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_HIT,
        S_REFILL,
        S_FENCE
    } state_t;

    state_t                           state_q;
    logic [icache_pkg::ADDR_W-1:0]    req_addr_q;
    logic [icache_pkg::INDEX_W-1:0]   walk_q;
    logic                             way_q;  // hit way, or the way to fill.
    logic                             issue_q;
    logic [icache_pkg::TAG_W-1:0]     req_tag;
    logic                             hit0;
    logic                             hit1;
    logic                             fill_way;
    logic                             deliver;
    logic                             fill;
    icache_pkg::line_t                hit_line;

    function automatic logic [icache_pkg::INST_W-1:0] pick_word(
        input icache_pkg::line_t line,
        input logic              sel
    );
        return sel ? line[icache_pkg::INST_W +: icache_pkg::INST_W]
                   : line[0 +: icache_pkg::INST_W];
    endfunction

    assign req_tag = req_addr_q[icache_pkg::ADDR_W-1 -: icache_pkg::TAG_W];

    assign hit0 = tag0_rdata_i.valid && (tag0_rdata_i.tag == req_tag);
    assign hit1 = tag1_rdata_i.valid && (tag1_rdata_i.tag == req_tag);

    // an empty way is filled before the age counters are asked.
    assign fill_way = !tag0_rdata_i.valid ? 1'b0 :
                      !tag1_rdata_i.valid ? 1'b1 : victim_way_i;

    assign hit_line = way_q ? data1_rdata_i : data0_rdata_i;

    assign fill = (state_q == S_REFILL) && mem_valid_i;
    assign deliver = (state_q == S_HIT) || fill;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= S_IDLE;
            walk_q <= '0;
            issue_q <= 1'b0;
            mem_req_o <= 1'b0;
            fetch_valid_o <= 1'b0;
        end else begin
            fetch_valid_o <= 1'b0;
            issue_q <= 1'b0;
            mem_req_o <= issue_q;  // request leaves one cycle after the miss is known.
            case (state_q)
                S_IDLE: begin
                    if (fence_i && fetch_ready_o) begin
                        state_q <= S_FENCE;
                        walk_q <= '0;
                    end else if (fetch_req_i && fetch_ready_o) begin
                        state_q <= S_LOOKUP;
                    end
                end
                S_LOOKUP: begin
                    if (hit0 || hit1) begin
                        state_q <= S_HIT;
                    end else begin
                        state_q <= S_REFILL;
                        issue_q <= 1'b1;
                    end
                end
                S_HIT: begin
                    fetch_valid_o <= 1'b1;
                    state_q <= S_IDLE;
                end
                S_REFILL: begin
                    if (mem_valid_i) begin
                        fetch_valid_o <= 1'b1;
                        state_q <= S_IDLE;
                    end
                end
                S_FENCE: begin
                    walk_q <= walk_q + 1'b1;
                    if (walk_q == icache_pkg::INDEX_W'(icache_pkg::SETS - 1)) begin
                        state_q <= S_IDLE;
                    end
                end
                default: begin
                    state_q <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == S_IDLE && fetch_req_i) begin
            req_addr_q <= fetch_addr_i;
        end
        if (state_q == S_LOOKUP) begin
            way_q <= hit1 ? 1'b1 : (hit0 ? 1'b0 : fill_way);
        end
        if (state_q == S_HIT) begin
            fetch_data_o <= pick_word(hit_line, req_addr_q[2]);
        end else if (fill) begin
            fetch_data_o <= pick_word(mem_data_i, req_addr_q[2]);
        end
    end

    always_comb begin
        case (state_q)
            S_IDLE:  arr_addr_o = fetch_addr_i[3 +: icache_pkg::INDEX_W];
            S_FENCE: arr_addr_o = walk_q;
            default: arr_addr_o = req_addr_q[3 +: icache_pkg::INDEX_W];
        endcase
    end

    assign fetch_ready_o = (state_q == S_IDLE) && !fetch_valid_o;
    assign mem_addr_o = {req_addr_q[icache_pkg::ADDR_W-1:3], 3'b000};

    // the fence writes invalid entries into both ways of the walked set.
    assign tag_we_o = (state_q == S_FENCE) ? 2'b11 :
                      fill ? {way_q, !way_q} : 2'b00;
    assign tag_wdata_o.valid = (state_q != S_FENCE);
    assign tag_wdata_o.tag = (state_q == S_FENCE) ? '0 : req_tag;
    assign data_we_o = fill ? {way_q, !way_q} : 2'b00;

    assign age_touch_o = deliver;
    assign age_way_o = way_q;
    assign age_deliver_o = deliver;

endmodule

/* hw/icache_top.sv */
`timescale 1ns/1ns
// Two-way set-associative instruction cache, 64 sets of one 64-bit line per way.
// Fetch and memory sides both use single-cycle strobes.
module icache_top (
    input  logic                          clk,
    input  logic                          reset_i,
    input  logic                          fetch_req_i,
    input  logic [icache_pkg::ADDR_W-1:0] fetch_addr_i,
    input  logic                          fence_i,
    output logic                          fetch_ready_o,
    output logic                          fetch_valid_o,
    output logic [icache_pkg::INST_W-1:0] fetch_data_o,
    output logic                          mem_req_o,
    output logic [icache_pkg::ADDR_W-1:0] mem_addr_o,
    input  logic                          mem_valid_i,
    input  icache_pkg::line_t             mem_data_i
);

    logic [icache_pkg::INDEX_W-1:0] arr_addr;
    logic [1:0]                     tag_we;
    logic [1:0]                     data_we;
    icache_pkg::tag_entry_t         tag_wdata;
    icache_pkg::tag_entry_t         tag0_rdata;
    icache_pkg::tag_entry_t         tag1_rdata;
    icache_pkg::line_t              data0_rdata;
    icache_pkg::line_t              data1_rdata;
    logic                           age_touch;
    logic                           age_way;
    logic                           age_deliver;
    logic                           victim_way;

    icache_ctrl ctrl_i (
        .clk           (clk),
        .reset_i       (reset_i),
        .fetch_req_i   (fetch_req_i),
        .fetch_addr_i  (fetch_addr_i),
        .fence_i       (fence_i),
        .fetch_ready_o (fetch_ready_o),
        .fetch_valid_o (fetch_valid_o),
        .fetch_data_o  (fetch_data_o),
        .mem_req_o     (mem_req_o),
        .mem_addr_o    (mem_addr_o),
        .mem_valid_i   (mem_valid_i),
        .mem_data_i    (mem_data_i),
        .arr_addr_o    (arr_addr),
        .tag_we_o      (tag_we),
        .tag_wdata_o   (tag_wdata),
        .tag0_rdata_i  (tag0_rdata),
        .tag1_rdata_i  (tag1_rdata),
        .data_we_o     (data_we),
        .data0_rdata_i (data0_rdata),
        .data1_rdata_i (data1_rdata),
        .age_touch_o   (age_touch),
        .age_way_o     (age_way),
        .age_deliver_o (age_deliver),
        .victim_way_i  (victim_way)
    );

    icache_age age_i (
        .clk          (clk),
        .reset_i      (reset_i),
        .index_i      (arr_addr),
        .touch_i      (age_touch),
        .touch_way_i  (age_way),
        .deliver_i    (age_deliver),
        .victim_way_o (victim_way)
    );

    icache_sram #(.entry_t(icache_pkg::tag_entry_t)) tag_way0 (
        .clk(clk), .addr_i(arr_addr), .we_i(tag_we[0]), .wdata_i(tag_wdata), .rdata_o(tag0_rdata)
    );

    icache_sram #(.entry_t(icache_pkg::tag_entry_t)) tag_way1 (
        .clk(clk), .addr_i(arr_addr), .we_i(tag_we[1]), .wdata_i(tag_wdata), .rdata_o(tag1_rdata)
    );

    // refill data comes straight from the memory port.
    icache_sram #(.entry_t(icache_pkg::line_t)) data_way0 (
        .clk(clk), .addr_i(arr_addr), .we_i(data_we[0]), .wdata_i(mem_data_i), .rdata_o(data0_rdata)
    );

    icache_sram #(.entry_t(icache_pkg::line_t)) data_way1 (
        .clk(clk), .addr_i(arr_addr), .we_i(data_we[1]), .wdata_i(mem_data_i), .rdata_o(data1_rdata)
    );

endmodule

/* verification/icache_assertions.sv */
`timescale 1ns/1ns
// Protocol checks for the instruction cache, bound into icache_top.
// Covers pulse widths, the fence walk and the single outstanding refill.
module icache_assertions (
    input logic clk,
    input logic reset_i,
    input logic fence_i,
    input logic fetch_ready_i,
    input logic fetch_valid_i,
    input logic mem_req_i,
    input logic mem_valid_i
);

    logic [7:0] walk_left;  // sets still to be cleared by the fence.
    logic       refill_open;
    int         fail_count = 0;  // number of failed assertions so far.

    always_ff @(posedge clk) begin
        if (reset_i) begin
            walk_left <= '0;
            refill_open <= 1'b0;
        end else begin
            if (fence_i && fetch_ready_i) begin
                walk_left <= 8'(icache_pkg::SETS);
            end else if (walk_left != 8'd0) begin
                walk_left <= walk_left - 8'd1;
            end
            if (mem_req_i) begin
                refill_open <= 1'b1;
            end else if (mem_valid_i) begin
                refill_open <= 1'b0;
            end
        end
    end

    valid_pulse: assert property (@(posedge clk) disable iff (reset_i)
        fetch_valid_i |=> !fetch_valid_i)
        else begin
            fail_count++;
            $error("fetch_valid_o stayed high for more than one cycle");
        end

    mem_req_pulse: assert property (@(posedge clk) disable iff (reset_i)
        mem_req_i |=> !mem_req_i)
        else begin
            fail_count++;
            $error("mem_req_o stayed high for more than one cycle");
        end

    fence_not_ready: assert property (@(posedge clk) disable iff (reset_i)
        (walk_left != 8'd0) |-> !fetch_ready_i)
        else begin
            fail_count++;
            $error("fetch_ready_o rose while the fence walk was running");
        end

    single_refill: assert property (@(posedge clk) disable iff (reset_i)
        mem_req_i |-> !refill_open)
        else begin
            fail_count++;
            $error("mem_req_o rose while a refill was still outstanding");
        end

endmodule

bind icache_top icache_assertions icache_assertions_i (
    .clk           (clk),
    .reset_i       (reset_i),
    .fence_i       (fence_i),
    .fetch_ready_i (fetch_ready_o),
    .fetch_valid_i (fetch_valid_o),
    .mem_req_i     (mem_req_o),
    .mem_valid_i   (mem_valid_i)
);

/* verification/icache_tb.sv */
`timescale 1ns/1ns
// Testbench for the instruction cache. A table of fetches and fences runs against
// a memory model whose lines follow from the aligned address and a generation value.
module icache_tb;

    logic                          clk = 1'b0;
    logic                          reset_i = 1'b1;
    logic                          fetch_req_i = 1'b0;
    logic [icache_pkg::ADDR_W-1:0] fetch_addr_i = '0;
    logic                          fence_i = 1'b0;
    logic                          fetch_ready_o;
    logic                          fetch_valid_o;
    logic [icache_pkg::INST_W-1:0] fetch_data_o;
    logic                          mem_req_o;
    logic [icache_pkg::ADDR_W-1:0] mem_addr_o;
    logic                          mem_valid_i = 1'b0;
    icache_pkg::line_t             mem_data_i = '0;

    integer      seed = 32'h3459198f;
    int          mem_wait = 0;
    int          mem_req_count = 0;
    logic [31:0] mem_addr_q = '0;
    logic [31:0] gen = 32'h5a5a_0000;  // moves on after every fence.
    int          wait_limit = 200;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    bit          timed_out = 1'b0;

    logic [31:0] step_addr [$];
    bit          step_fence [$];
    bit          step_miss [$];
    string       step_note [$];

    icache_top icache_top_i (
        .clk           (clk),
        .reset_i       (reset_i),
        .fetch_req_i   (fetch_req_i),
        .fetch_addr_i  (fetch_addr_i),
        .fence_i       (fence_i),
        .fetch_ready_o (fetch_ready_o),
        .fetch_valid_o (fetch_valid_o),
        .fetch_data_o  (fetch_data_o),
        .mem_req_o     (mem_req_o),
        .mem_addr_o    (mem_addr_o),
        .mem_valid_i   (mem_valid_i),
        .mem_data_i    (mem_data_i)
    );

    initial begin
        forever #5 clk = ~clk;
    end

    // low half is the address, high half its inverse, both mixed with the generation.
    function automatic icache_pkg::line_t memory_line(input logic [31:0] addr,
                                                      input logic [31:0] g);
        return {~addr ^ g, addr ^ g};
    endfunction

    function automatic logic [31:0] expected_word(input logic [31:0] addr,
                                                  input logic [31:0] g);
        logic [31:0] base;
        base = {addr[31:3], 3'b000};
        if (addr[2]) begin
            return ~base ^ g;
        end
        return base ^ g;
    endfunction

    // memory answers each request after 1 to 4 cycles.
    always @(posedge clk) begin
        mem_valid_i <= 1'b0;
        if (mem_wait != 0) begin
            mem_wait <= mem_wait - 1;
            if (mem_wait == 1) begin
                mem_valid_i <= 1'b1;
                mem_data_i <= memory_line(mem_addr_q, gen);
            end
        end else if (mem_req_o) begin
            mem_wait <= 1 + int'($unsigned($random(seed)) % 4);
            mem_addr_q <= mem_addr_o;
            mem_req_count <= mem_req_count + 1;
        end
    end

    task automatic add_step(input logic [31:0] addr, input bit fence, input bit miss,
                            input string note);
        step_addr.push_back(addr);
        step_fence.push_back(fence);
        step_miss.push_back(miss);
        step_note.push_back(note);
    endtask

    task automatic wait_for_ready();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!fetch_ready_o && !timed_out) begin
            if (cycles >= wait_limit) begin
                $display("Timed out at %0t waiting for fetch_ready_o", $time);
                timed_out = 1'b1;
            end else begin
                @(negedge clk);
                cycles++;
            end
        end
    endtask

    // edges counts clock edges after the request edge until fetch_valid_o is seen.
    task automatic collect_response(output int edges);
        edges = 0;
        @(negedge clk);
        while (!fetch_valid_o && !timed_out) begin
            if (edges >= wait_limit) begin
                $display("Timed out at %0t waiting for fetch_valid_o", $time);
                timed_out = 1'b1;
            end else begin
                @(negedge clk);
                edges++;
            end
        end
    endtask

    task automatic fetch_and_check(input logic [31:0] addr, input bit miss);
        int          reqs_before;
        int          edges;
        logic [31:0] expected;
        wait_for_ready();
        if (timed_out) return;
        reqs_before = mem_req_count;
        @(posedge clk);
        fetch_req_i <= 1'b1;
        fetch_addr_i <= addr;
        @(posedge clk);
        fetch_req_i <= 1'b0;
        collect_response(edges);
        if (timed_out) return;
        expected = expected_word(addr, gen);
        checks += 3;
        assert (fetch_data_o === expected) else begin
            $display("ERROR %0t: fetch %h returned %h, expected %h",
                     $time, addr, fetch_data_o, expected);
            errors++;
        end
        assert ((mem_req_count - reqs_before) == (miss ? 1 : 0)) else begin
            $display("ERROR %0t: fetch %h made %0d memory requests, expected %0d",
                     $time, addr, mem_req_count - reqs_before, miss ? 1 : 0);
            errors++;
        end
        if (miss) begin
            assert (mem_addr_q == {addr[31:3], 3'b000}) else begin
                $display("ERROR %0t: refill address %h for fetch %h", $time, mem_addr_q, addr);
                errors++;
            end
        end else begin
            assert (edges == 2) else begin
                $display("ERROR %0t: hit latency %0d cycles, expected 2", $time, edges);
                errors++;
            end
        end
    endtask

    task automatic fence_and_check();
        int walk;
        walk = 0;
        wait_for_ready();
        if (timed_out) return;
        @(posedge clk);
        fence_i <= 1'b1;
        @(posedge clk);
        fence_i <= 1'b0;
        @(negedge clk);
        while (!fetch_ready_o && !timed_out) begin
            checks++;
            assert (!fetch_valid_o && !mem_req_o) else begin
                $display("ERROR %0t: fetch or memory strobe during the fence walk", $time);
                errors++;
            end
            if (walk >= wait_limit) begin
                $display("Timed out at %0t waiting for the fence walk to end", $time);
                timed_out = 1'b1;
            end else begin
                @(negedge clk);
                walk++;
            end
        end
        checks++;
        assert (walk == icache_pkg::SETS) else begin
            $display("ERROR %0t: fence walk took %0d cycles, expected %0d",
                     $time, walk, icache_pkg::SETS);
            errors++;
        end
        gen = gen + 32'h0101_0101;
    endtask

    initial begin : stimulus
        int errors_before;
        // index 5 holds tags 8, 16 and 24 in turn.
        add_step(32'h0000_0000, 1'b1, 1'b0, "fence after reset");
        add_step(32'h0000_1028, 1'b0, 1'b1, "cold miss fills way 0");
        add_step(32'h0000_1028, 1'b0, 1'b0, "repeat fetch hits way 0");
        add_step(32'h0000_102c, 1'b0, 1'b0, "other word of the line hits");
        add_step(32'h0000_2028, 1'b0, 1'b1, "second tag fills way 1");
        add_step(32'h0000_1028, 1'b0, 1'b0, "first tag still resident");
        add_step(32'h0000_2028, 1'b0, 1'b0, "second tag still resident");
        add_step(32'h0000_3028, 1'b0, 1'b1, "third tag evicts way 0");
        add_step(32'h0000_202c, 1'b0, 1'b0, "way 1 tag survives");
        add_step(32'h0000_1028, 1'b0, 1'b1, "evicted tag refills way 0");
        add_step(32'h0000_2028, 1'b0, 1'b0, "way 1 tag still hits");
        add_step(32'h0000_102c, 1'b0, 1'b0, "way 0 tag hits again");
        add_step(32'h0000_3028, 1'b0, 1'b1, "third tag evicts way 1");
        add_step(32'h0000_1028, 1'b0, 1'b0, "way 0 tag survives");
        add_step(32'h0000_2028, 1'b0, 1'b1, "evicted tag refills way 1");
        add_step(32'hffff_fe04, 1'b0, 1'b1, "top tag at index 0 fills way 0");
        add_step(32'hffff_fe00, 1'b0, 1'b0, "top tag other word hits");
        add_step(32'h0000_01fc, 1'b0, 1'b1, "last set fills way 0");
        add_step(32'h0000_0000, 1'b1, 1'b0, "fence clears all sets");
        add_step(32'h0000_1028, 1'b0, 1'b1, "first tag misses after fence");
        add_step(32'h0000_202c, 1'b0, 1'b1, "second tag misses after fence");
        add_step(32'h0000_01f8, 1'b0, 1'b1, "last set misses after fence");
        add_step(32'h0000_102c, 1'b0, 1'b0, "new generation line hits");
        repeat (2) @(posedge clk);
        reset_i <= 1'b0;
        @(negedge clk);
        checks++;
        assert (fetch_ready_o === 1'b1 && fetch_valid_o === 1'b0 && mem_req_o === 1'b0)
        else begin
            $display("ERROR %0t: after reset ready=%b valid=%b mem_req=%b",
                     $time, fetch_ready_o, fetch_valid_o, mem_req_o);
            errors++;
        end
        tests++;
        $display("test reset state: %s", (errors == 0) ? "ok" : "mismatch");
        for (int i = 0; i < step_addr.size() && !timed_out; i++) begin
            errors_before = errors;
            if (step_fence[i]) begin
                fence_and_check();
            end else begin
                fetch_and_check(step_addr[i], step_miss[i]);
            end
            tests++;
            $display("test %0d %h %s: %s", i, step_addr[i], step_note[i],
                     (errors == errors_before && !timed_out) ? "ok" : "mismatch");
        end
        errors_before = errors;
        checks++;
        assert (icache_top_i.icache_assertions_i.fail_count == 0) else begin
            $display("Bound protocol assertions failed %0d times",
                     icache_top_i.icache_assertions_i.fail_count);
            errors++;
        end
        tests++;
        $display("test protocol assertions: %s",
                 (errors == errors_before) ? "ok" : "mismatch");
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* sim.f */
hw/icache_pkg.sv
hw/icache_sram.sv
hw/icache_age.sv
hw/icache_ctrl.sv
hw/icache_top.sv
verification/icache_assertions.sv
verification/icache_tb.sv

/* Makefile */
# Verilator build and run of the instruction cache testbench.
# The run passes only when the log holds the pass line.

VERILATOR ?= verilator
TOP       ?= icache_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
EXTRA     ?= -Wno-fatal
JOBS      ?= 0

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --assert -j $(JOBS) $(EXTRA) \
		--top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
